//--- design/if_settings.svh
/*
  widths, fixed addresses, fetch queue depth and register offsets
  shared by the instruction fetch stage
*/
`ifndef IF_SETTINGS_SVH
`define IF_SETTINGS_SVH

// datapath widths
`define IF_ADDR_W          32
`define IF_INSTR_W         32

// boot entry sits this far above the boot base
`define IF_BOOT_OFFSET     32'h0000_0080
// debug module entry points
`define IF_DM_HALT_ADDR    32'h1A11_0800
`define IF_DM_EXC_ADDR     32'h1A11_0808

// fetch queue depth, 2 or more
`define IF_FIFO_DEPTH      2

// AXI4-Lite register offsets
`define IF_REG_BOOT        4'h0
`define IF_REG_MTVEC       4'h4
`define IF_REG_MEPC        4'h8
`define IF_REG_DEPC        4'hC

`define IF_RESET_BOOT_BASE 32'h0000_0000

`endif

//--- design/if_pkg.sv
/*
  fetch stage types: address, instruction word, interrupt cause,
  next-PC and exception target selects, AXI response code
*/
`include "if_settings.svh"

package if_pkg;

  // instruction address and fetched word
  typedef logic [`IF_ADDR_W-1:0]  addr_t;
  typedef logic [`IF_INSTR_W-1:0] instr_t;

  // interrupt number used for vectored entry
  typedef logic [4:0] irq_cause_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // AXI response code, only OKAY is ever returned
  typedef logic [1:0] axi_resp_t;
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

//--- design/if_csr_regs.sv
/*
  AXI4-Lite register block with boot base, trap vector base,
  exception return PC and debug return PC
*/
`include "if_settings.svh"

module if_csr_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  // AXI4-Lite slave
  input  if_pkg::addr_t     s_axi_awaddr_i,
  input  logic              s_axi_awvalid_i,
  output logic              s_axi_awready_o,
  input  if_pkg::addr_t     s_axi_wdata_i,
  input  logic              s_axi_wvalid_i,
  output logic              s_axi_wready_o,
  output if_pkg::axi_resp_t s_axi_bresp_o,
  output logic              s_axi_bvalid_o,
  input  logic              s_axi_bready_i,
  input  if_pkg::addr_t     s_axi_araddr_i,
  input  logic              s_axi_arvalid_i,
  output logic              s_axi_arready_o,
  output if_pkg::addr_t     s_axi_rdata_o,
  output if_pkg::axi_resp_t s_axi_rresp_o,
  output logic              s_axi_rvalid_o,
  input  logic              s_axi_rready_i,
  // fetch side
  input  logic              boot_redirect_i,
  output if_pkg::addr_t     boot_base_o,
  output if_pkg::addr_t     mtvec_o,
  output if_pkg::addr_t     mepc_o,
  output if_pkg::addr_t     depc_o
);
  import if_pkg::*;

  addr_t      boot_base_q, mtvec_q, mepc_q, depc_q;
  addr_t      rdata_q, rd_data;
  logic       bvalid_q, rvalid_q;
  logic       wr_en, rd_en;
  logic [3:0] wr_off, rd_off;

  ////////////////////
  // handshakes
  ////////////////////

  // address and data are taken together, once the last response is gone
  assign wr_en           = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q;
  assign s_axi_awready_o = wr_en;
  assign s_axi_wready_o  = wr_en;
  // one read in flight at a time
  assign s_axi_arready_o = ~rvalid_q;
  assign rd_en           = s_axi_arvalid_i & ~rvalid_q;

  // word offsets only
  assign wr_off = {s_axi_awaddr_i[3:2], 2'b00};
  assign rd_off = {s_axi_araddr_i[3:2], 2'b00};

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_base_q <= `IF_RESET_BOOT_BASE;
      mtvec_q     <= `IF_RESET_BOOT_BASE;
      mepc_q      <= '0;
      depc_q      <= '0;
    end else begin
      if (wr_en) begin
        case (wr_off)
          // boot and mtvec are 256 byte aligned
          `IF_REG_BOOT:  boot_base_q <= {s_axi_wdata_i[`IF_ADDR_W-1:8], 8'h00};
          `IF_REG_MTVEC: mtvec_q     <= {s_axi_wdata_i[`IF_ADDR_W-1:8], 8'h00};
          `IF_REG_MEPC:  mepc_q      <= s_axi_wdata_i;
          default:       depc_q      <= s_axi_wdata_i;
        endcase
      end
      // boot redirect reloads the trap vector, wins over a same-cycle write
      if (boot_redirect_i) begin
        mtvec_q <= boot_base_q;
      end
    end
  end

  // read mux
  always_comb begin
    case (rd_off)
      `IF_REG_BOOT:  rd_data = boot_base_q;
      `IF_REG_MTVEC: rd_data = mtvec_q;
      `IF_REG_MEPC:  rd_data = mepc_q;
      default:       rd_data = depc_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_data;
    end
  end

  ////////////////////
  // responses
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // held until the master takes it
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (s_axi_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (s_axi_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = AXI_RESP_OKAY;
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rdata_o  = rdata_q;
  assign s_axi_rresp_o  = AXI_RESP_OKAY;

  assign boot_base_o = boot_base_q;
  assign mtvec_o     = mtvec_q;
  assign mepc_o      = mepc_q;
  assign depc_o      = depc_q;

endmodule

//--- design/if_pc_select.sv
/*
  exception target computation and next fetch address mux
*/
`include "if_settings.svh"

module if_pc_select (
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_cause_t  exc_cause_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       boot_base_i,
  input  if_pkg::addr_t       mtvec_i,
  input  if_pkg::addr_t       mepc_i,
  input  if_pkg::addr_t       depc_i,
  output if_pkg::addr_t       fetch_addr_n_o,
  output logic                boot_redirect_o
);
  import if_pkg::*;

  addr_t exc_pc;
  addr_t boot_pc;

  // boot entry point
  assign boot_pc = boot_base_i + addr_t'(`IF_BOOT_OFFSET);

  always_comb begin : exc_pc_mux
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_i;
      // vectored, one word per interrupt line
      EXC_PC_IRQ:     exc_pc = mtvec_i + addr_t'({exc_cause_i, 2'b00});
      EXC_PC_DBD:     exc_pc = addr_t'(`IF_DM_HALT_ADDR);
      EXC_PC_DBG_EXC: exc_pc = addr_t'(`IF_DM_EXC_ADDR);
      default:        exc_pc = mtvec_i;
    endcase
  end

  always_comb begin : fetch_addr_mux
    case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap or debug
      PC_ERET: fetch_addr_n_o = mepc_i;
      PC_DRET: fetch_addr_n_o = depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // trap vector follows the boot base on a boot redirect
  assign boot_redirect_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

//--- design/if_fetch_buffer.sv
/*
  instruction bus request engine with an in-order response queue,
  discards stale responses after a redirect
*/
`include "if_settings.svh"

module if_fetch_buffer #(
  parameter int unsigned depth = `IF_FIFO_DEPTH
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           branch_i,
  input  if_pkg::addr_t  branch_addr_i,
  // queue head towards IF/ID
  input  logic           fetch_ready_i,
  output logic           fetch_valid_o,
  output if_pkg::instr_t fetch_rdata_o,
  output if_pkg::addr_t  fetch_addr_o,
  output logic           fetch_err_o,
  // instruction bus
  output logic           instr_req_o,
  output if_pkg::addr_t  instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  if_pkg::instr_t instr_rdata_i,
  input  logic           instr_err_i,
  output logic           busy_o
);
  import if_pkg::*;

  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);
  localparam logic [cnt_w:0] max_inflight = (cnt_w + 1)'(depth);

  logic [cnt_w-1:0] out_cnt_q, out_cnt_d, disc_cnt_q, disc_cnt_d;
  logic [cnt_w-1:0] fifo_cnt_q, fifo_cnt_d;
  logic [cnt_w:0]   in_flight;
  logic [ptr_w-1:0] rd_ptr_q, rd_ptr_d, wr_ptr_q, wr_ptr_d;
  addr_t            fetch_addr_q, fetch_addr_d, resp_addr_q, resp_addr_d;
  addr_t            branch_addr_al;
  logic             gnt, drop, push, pop;

  // queue storage
  instr_t           rdata_mem [depth];
  addr_t            addr_mem  [depth];
  logic [depth-1:0] err_mem;

  // wraps for any depth, not only powers of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // bus side
  ////////////////////

  assign branch_addr_al = {branch_addr_i[`IF_ADDR_W-1:2], 2'b00};

  // outstanding plus queued never exceeds the queue depth
  assign in_flight    = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_q};
  // nothing is requested in the redirect cycle itself
  assign instr_req_o  = req_i & ~branch_i & (in_flight < max_inflight);
  assign instr_addr_o = fetch_addr_q;
  assign gnt          = instr_req_o & instr_gnt_i;

  // responses to pre-redirect requests are dropped
  assign drop = instr_rvalid_i & (disc_cnt_q != '0);
  assign push = instr_rvalid_i & ~drop & ~branch_i;

  ////////////////////
  // queue side
  ////////////////////

  assign fetch_valid_o = (fifo_cnt_q != '0);
  assign pop           = fetch_valid_o & fetch_ready_i;

  always_comb begin
    out_cnt_d    = out_cnt_q + cnt_w'(gnt) - cnt_w'(instr_rvalid_i);
    fetch_addr_d = fetch_addr_q;
    resp_addr_d  = resp_addr_q;
    disc_cnt_d   = disc_cnt_q;
    fifo_cnt_d   = fifo_cnt_q;
    rd_ptr_d     = rd_ptr_q;
    wr_ptr_d     = wr_ptr_q;
    if (branch_i) begin
      // flush the queue, whatever is still on the bus is stale
      fetch_addr_d = branch_addr_al;
      resp_addr_d  = branch_addr_al;
      disc_cnt_d   = out_cnt_d;
      fifo_cnt_d   = '0;
      rd_ptr_d     = '0;
      wr_ptr_d     = '0;
    end else begin
      if (gnt) begin
        fetch_addr_d = fetch_addr_q + addr_t'(4);
      end
      if (drop) begin
        disc_cnt_d = disc_cnt_q - cnt_w'(1);
      end
      // in-order responses, so the address just follows along
      if (push) begin
        resp_addr_d = resp_addr_q + addr_t'(4);
        wr_ptr_d    = ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_d = ptr_inc(rd_ptr_q);
      end
      fifo_cnt_d = fifo_cnt_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
      fifo_cnt_q   <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
    end else begin
      out_cnt_q    <= out_cnt_d;
      disc_cnt_q   <= disc_cnt_d;
      fifo_cnt_q   <= fifo_cnt_d;
      rd_ptr_q     <= rd_ptr_d;
      wr_ptr_q     <= wr_ptr_d;
      fetch_addr_q <= fetch_addr_d;
      resp_addr_q  <= resp_addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rdata_mem[wr_ptr_q] <= instr_rdata_i;
      addr_mem[wr_ptr_q]  <= resp_addr_q;
      err_mem[wr_ptr_q]   <= instr_err_i;
    end
  end

  assign fetch_rdata_o = rdata_mem[rd_ptr_q];
  assign fetch_addr_o  = addr_mem[rd_ptr_q];
  assign fetch_err_o   = err_mem[rd_ptr_q];

  // still waiting on the bus
  assign busy_o = instr_req_o | (out_cnt_q != '0);

endmodule

//--- design/if_id_pipe.sv
/*
  IF/ID pipeline register with valid and new flags
  and the sequential PC check
*/
module if_id_pipe (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           fetch_valid_i,
  input  if_pkg::instr_t fetch_rdata_i,
  input  if_pkg::addr_t  fetch_addr_i,
  input  logic           fetch_err_i,
  input  logic           id_in_ready_i,
  input  logic           pc_set_i,
  input  logic           instr_valid_clear_i,
  output logic           fetch_ready_o,
  output logic           instr_valid_id_o,
  output logic           instr_new_id_o,
  output if_pkg::instr_t instr_rdata_id_o,
  output logic           instr_fetch_err_o,
  output if_pkg::addr_t  pc_id_o,
  output logic           pc_mismatch_alert_o
);
  import if_pkg::*;

  logic  load;
  logic  valid_d, valid_q;
  logic  new_d, new_q;
  logic  seq_d, seq_q;
  addr_t pc_seq;

  // no skid buffer, ID ready goes straight to the queue
  assign fetch_ready_o = id_in_ready_i;
  assign load          = fetch_valid_i & fetch_ready_o;

  // a redirect in the loading cycle squashes the word
  assign valid_d = (load & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);
  assign new_d   = load & ~pc_set_i;

  // sequential since the last redirect, off after reset
  assign seq_d = (seq_q | load) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
      seq_q   <= seq_d;
    end
  end

  // payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      instr_fetch_err_o <= fetch_err_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // word fetch only, PC always steps by 4
  assign pc_seq = pc_id_o + addr_t'(4);
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_addr_i != pc_seq);

endmodule

//--- design/if_stage_top.sv
/*
  instruction fetch stage top, register block, PC selection,
  fetch buffer and IF/ID register
*/
module if_stage_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // AXI4-Lite slave
  input  if_pkg::addr_t       s_axi_awaddr_i,
  input  logic                s_axi_awvalid_i,
  output logic                s_axi_awready_o,
  input  if_pkg::addr_t       s_axi_wdata_i,
  input  logic                s_axi_wvalid_i,
  output logic                s_axi_wready_o,
  output if_pkg::axi_resp_t   s_axi_bresp_o,
  output logic                s_axi_bvalid_o,
  input  logic                s_axi_bready_i,
  input  if_pkg::addr_t       s_axi_araddr_i,
  input  logic                s_axi_arvalid_i,
  output logic                s_axi_arready_o,
  output if_pkg::addr_t       s_axi_rdata_o,
  output if_pkg::axi_resp_t   s_axi_rresp_o,
  output logic                s_axi_rvalid_o,
  input  logic                s_axi_rready_i,
  // core control
  input  logic                req_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_cause_t  exc_cause_i,
  input  if_pkg::addr_t       branch_target_i,
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  // instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_err_i,
  // towards ID
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::instr_t      instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_id_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                pc_mismatch_alert_o,
  output logic                if_busy_o
);
  import if_pkg::*;

  addr_t  boot_base, mtvec, mepc, depc;
  addr_t  fetch_addr_n;
  instr_t fetch_rdata;
  logic   boot_redirect;
  logic   fetch_valid, fetch_ready, fetch_err;

  // AXI and clock ports connect by name
  if_csr_regs csr_regs_i (
    .boot_redirect_i (boot_redirect),
    .boot_base_o     (boot_base),
    .mtvec_o         (mtvec),
    .mepc_o          (mepc),
    .depc_o          (depc),
    .*
  );

  // core select inputs connect by name
  if_pc_select pc_select_i (
    .boot_base_i     (boot_base),
    .mtvec_i         (mtvec),
    .mepc_i          (mepc),
    .depc_i          (depc),
    .fetch_addr_n_o  (fetch_addr_n),
    .boot_redirect_o (boot_redirect),
    .*
  );

  // every pc_set_i restarts the fetch stream
  if_fetch_buffer fetch_buffer_i (
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .fetch_ready_i   (fetch_ready),
    .fetch_valid_o   (fetch_valid),
    .fetch_rdata_o   (fetch_rdata),
    .fetch_addr_o    (pc_if_o),
    .fetch_err_o     (fetch_err),
    .busy_o          (if_busy_o),
    .*
  );

  // queue head address is the IF PC
  if_id_pipe id_pipe_i (
    .fetch_valid_i   (fetch_valid),
    .fetch_rdata_i   (fetch_rdata),
    .fetch_addr_i    (pc_if_o),
    .fetch_err_i     (fetch_err),
    .fetch_ready_o   (fetch_ready),
    .*
  );

endmodule

//--- sim/tb_clock_gen.sv
/*
  testbench clock, period 100, and active low reset held 5 cycles
*/
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- sim/if_stage_properties.sv
/*
  checker bound to the fetch stage top, reference model of the
  registers and the expected fetch PC, concurrent assertions on the ports
*/
module if_stage_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input if_pkg::addr_t       s_axi_awaddr_i,
  input logic                s_axi_awvalid_i,
  input logic                s_axi_awready_o,
  input if_pkg::addr_t       s_axi_wdata_i,
  input logic                s_axi_wvalid_i,
  input logic                s_axi_wready_o,
  input if_pkg::axi_resp_t   s_axi_bresp_o,
  input logic                s_axi_bvalid_o,
  input if_pkg::addr_t       s_axi_araddr_i,
  input logic                s_axi_arvalid_i,
  input logic                s_axi_arready_o,
  input if_pkg::addr_t       s_axi_rdata_o,
  input if_pkg::axi_resp_t   s_axi_rresp_o,
  input logic                s_axi_rvalid_o,
  input logic                pc_set_i,
  input if_pkg::pc_sel_e     pc_mux_i,
  input if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input if_pkg::irq_cause_t  exc_cause_i,
  input if_pkg::addr_t       branch_target_i,
  input logic                instr_valid_clear_i,
  input logic                instr_req_o,
  input if_pkg::addr_t       instr_addr_o,
  input logic                instr_gnt_i,
  input logic                instr_rvalid_i,
  input logic                instr_valid_id_o,
  input logic                instr_new_id_o,
  input if_pkg::instr_t      instr_rdata_id_o,
  input logic                instr_fetch_err_o,
  input if_pkg::addr_t       pc_id_o,
  input if_pkg::addr_t       pc_if_o,
  input logic                pc_mismatch_alert_o,
  input logic                if_busy_o
);
  import if_pkg::*;

  int    fail_cnt = 0;
  addr_t m_boot, m_mtvec, m_mepc, m_depc, rd_exp, exp_pc;
  addr_t pc_if_q;

  ////////////////////
  // reference model
  ////////////////////

  function automatic addr_t reg_value(input logic [1:0] idx);
    case (idx)
      2'd0:    return m_boot;
      2'd1:    return m_mtvec;
      2'd2:    return m_mepc;
      default: return m_depc;
    endcase
  endfunction

  // where a redirect should land
  function automatic addr_t redirect_target();
    case (pc_mux_i)
      PC_JUMP: return branch_target_i;
      PC_ERET: return m_mepc;
      PC_DRET: return m_depc;
      PC_EXC: begin
        case (exc_pc_mux_i)
          EXC_PC_IRQ: return m_mtvec + 4 * exc_cause_i;
          EXC_PC_DBD: return 32'h1A11_0800;
          EXC_PC_DBG_EXC: return 32'h1A11_0808;
          default: return m_mtvec;
        endcase
      end
      default: return m_boot + 32'h80;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_boot  <= '0;
      m_mtvec <= '0;
      m_mepc  <= '0;
      m_depc  <= '0;
      rd_exp  <= '0;
      exp_pc  <= '0;
      pc_if_q <= '0;
    end else begin
      if (s_axi_awvalid_i && s_axi_awready_o && s_axi_wvalid_i && s_axi_wready_o) begin
        case (s_axi_awaddr_i[3:2])
          // low byte of boot and mtvec reads as zero
          2'd0:    m_boot  <= s_axi_wdata_i & 32'hFFFF_FF00;
          2'd1:    m_mtvec <= s_axi_wdata_i & 32'hFFFF_FF00;
          2'd2:    m_mepc  <= s_axi_wdata_i;
          default: m_depc  <= s_axi_wdata_i;
        endcase
      end
      if (pc_set_i && pc_mux_i == PC_BOOT) begin
        m_mtvec <= m_boot;
      end
      if (s_axi_arvalid_i && s_axi_arready_o) begin
        rd_exp <= reg_value(s_axi_araddr_i[3:2]);
      end
      // next expected ID PC
      if (pc_set_i) begin
        exp_pc <= redirect_target();
      end else if (instr_new_id_o) begin
        exp_pc <= exp_pc + 32'd4;
      end
      // queue head address one cycle back
      pc_if_q <= pc_if_o;
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !instr_req_o &&
      !instr_valid_id_o && !instr_new_id_o && !pc_mismatch_alert_o &&
      !s_axi_bvalid_o && !s_axi_rvalid_o)
    else begin
      fail_cnt++;
      $error("outputs not quiet during reset at %0t", $time);
    end

  bresp_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
      s_axi_bvalid_o |-> s_axi_bresp_o == 2'b00)
    else begin
      fail_cnt++;
      $error("** Error t=%0t s_axi_bresp_o got %h expected 0", $time, $sampled(s_axi_bresp_o));
    end

  rresp_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
      s_axi_rvalid_o |-> s_axi_rresp_o == 2'b00)
    else begin
      fail_cnt++;
      $error("** Error t=%0t s_axi_rresp_o got %h expected 0", $time, $sampled(s_axi_rresp_o));
    end

  rdata_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
      s_axi_rvalid_o |-> s_axi_rdata_o == rd_exp)
    else begin
      fail_cnt++;
      $error("** Error t=%0t s_axi_rdata_o got %h expected %h", $time,
             $sampled(s_axi_rdata_o), $sampled(rd_exp));
    end

  // covers boot, jump, returns, exception targets and sequential steps
  pc_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> pc_id_o == exp_pc)
    else begin
      fail_cnt++;
      $error("** Error t=%0t pc_id_o got %h expected %h", $time,
             $sampled(pc_id_o), $sampled(exp_pc));
    end

  // the word ID just took sat at the queue head one cycle earlier
  pc_if_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> pc_if_q == exp_pc)
    else begin
      fail_cnt++;
      $error("** Error t=%0t pc_if_o got %h expected %h", $time,
             $sampled(pc_if_q), $sampled(exp_pc));
    end

  data_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_rdata_id_o == (pc_id_o ^ 32'hA5A5_A5A5))
    else begin
      fail_cnt++;
      $error("** Error t=%0t instr_rdata_id_o got %h expected %h", $time,
             $sampled(instr_rdata_id_o), $sampled(pc_id_o) ^ 32'hA5A5_A5A5);
    end

  err_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_fetch_err_o == (pc_id_o >= 32'h3000 && pc_id_o <= 32'h30FF))
    else begin
      fail_cnt++;
      $error("** Error t=%0t instr_fetch_err_o got %b for pc %h", $time,
             $sampled(instr_fetch_err_o), $sampled(pc_id_o));
    end

  // valid stays up until ID clears it
  valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_valid_id_o && !instr_valid_clear_i |=> instr_valid_id_o)
    else begin
      fail_cnt++;
      $error("instr_valid_id_o dropped without instr_valid_clear_i at %0t", $time);
    end

  no_mismatch: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !pc_mismatch_alert_o)
    else begin
      fail_cnt++;
      $error("** Error t=%0t pc_mismatch_alert_o got 1 expected 0", $time);
    end

  // a response only comes back for a request still owed
  busy_on_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_rvalid_i |-> if_busy_o)
    else begin
      fail_cnt++;
      $error("** Error t=%0t if_busy_o got 0 expected 1", $time);
    end

  // an ungranted request holds unless a redirect takes it away
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_req_o && !instr_gnt_i |=> pc_set_i || (instr_req_o && $stable(instr_addr_o)))
    else begin
      fail_cnt++;
      $error("instruction request dropped or address changed before grant at %0t", $time);
    end

endmodule

bind if_stage_top if_stage_properties props_i (.*);

//--- sim/tb_if_stage.sv
/*
  testbench top for the fetch stage, instruction memory model,
  AXI4-Lite driver, directed redirects, watchdog and reporting
*/
module tb_if_stage;
  import if_pkg::*;

  // six tests, cycles each, with a margin of three
  localparam int sum_test_cycles = 300 + 600 + 1200 + 1200 + 1200 + 600;
  localparam int watchdog_cycles = 3 * sum_test_cycles;

  logic clk_i, rst_ni;
  addr_t s_axi_awaddr_i, s_axi_wdata_i, s_axi_araddr_i, s_axi_rdata_o;
  logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
  logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
  logic s_axi_rvalid_o, s_axi_rready_i;
  axi_resp_t s_axi_bresp_o, s_axi_rresp_o;
  logic req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_cause_t exc_cause_i;
  addr_t branch_target_i, instr_addr_o, pc_id_o, pc_if_o;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  instr_t instr_rdata_i, instr_rdata_id_o;
  logic instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic pc_mismatch_alert_o, if_busy_o;

  int seed = 99;
  int err_cnt = 0;
  int last_fails = 0;
  int test_cnt = 0;
  int cycle_cnt = 0;
  int last_due = 0;
  int due;
  addr_t pend_addr[$];
  int pend_due[$];
  addr_t resp_addr;

  tb_clock_gen clock_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

  if_stage_top if_stage_top_i (.*);

  ////////////////////
  // instruction memory
  ////////////////////

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (rst_ni && instr_req_o && instr_gnt_i) begin
      // answer 1 to 3 cycles after the grant, in order
      due = cycle_cnt + {$random(seed)} % 3;
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(due);
    end
    instr_gnt_i <= ({$random(seed)} % 4) != 0;
    if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
      resp_addr = pend_addr.pop_front();
      void'(pend_due.pop_front());
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= resp_addr ^ 32'hA5A5_A5A5;
      instr_err_i    <= (resp_addr >= 32'h3000 && resp_addr <= 32'h30FF);
    end else begin
      instr_rvalid_i <= 1'b0;
    end
  end

  // ID side, random stalls and valid clearing
  always @(posedge clk_i) begin
    if (rst_ni) begin
      id_in_ready_i       <= ({$random(seed)} % 4) != 0;
      instr_valid_clear_i <= instr_valid_id_o;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic int total_fails();
    return err_cnt + if_stage_top_i.props_i.fail_cnt;
  endfunction

  task automatic report_test(input string name);
    int now;
    now = total_fails();
    test_cnt++;
    if (now == last_fails) $display("test %s: ok", name);
    else $display("test %s: %0d failures", name, now - last_fails);
    last_fails = now;
  endtask

  task automatic axi_write(input addr_t addr, input addr_t data);
    @(posedge clk_i);
    s_axi_awaddr_i  <= addr;
    s_axi_wdata_i   <= data;
    s_axi_awvalid_i <= 1'b1;
    s_axi_wvalid_i  <= 1'b1;
    do @(posedge clk_i); while (!s_axi_awready_o);
    s_axi_awvalid_i <= 1'b0;
    s_axi_wvalid_i  <= 1'b0;
    do @(posedge clk_i); while (!s_axi_bvalid_o);
  endtask

  task automatic axi_read(input addr_t addr);
    @(posedge clk_i);
    s_axi_araddr_i  <= addr;
    s_axi_arvalid_i <= 1'b1;
    do @(posedge clk_i); while (!s_axi_arready_o);
    s_axi_arvalid_i <= 1'b0;
    do @(posedge clk_i); while (!s_axi_rvalid_o);
  endtask

  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc_sel,
                          input irq_cause_t cause, input addr_t target);
    @(posedge clk_i);
    pc_set_i        <= 1'b1;
    pc_mux_i        <= sel;
    exc_pc_mux_i    <= exc_sel;
    exc_cause_i     <= cause;
    branch_target_i <= target;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
  endtask

  // wait for n new ID instructions, bounded per instruction
  task automatic wait_new_instrs(input int n);
    int seen;
    int waited;
    seen = 0;
    waited = 0;
    while (seen < n && waited < 40 * n) begin
      @(posedge clk_i);
      if (instr_new_id_o) seen++;
      waited++;
    end
    if (seen < n) begin
      $display("timeout: only %0d of %0d instructions reached ID at %0t", seen, n, $time);
      err_cnt++;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    s_axi_awaddr_i = '0;
    s_axi_wdata_i = '0;
    s_axi_araddr_i = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wvalid_i = 1'b0;
    s_axi_arvalid_i = 1'b0;
    s_axi_bready_i = 1'b1;
    s_axi_rready_i = 1'b1;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exc_cause_i = '0;
    branch_target_i = '0;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    wait (rst_ni);

    axi_write(32'h0, 32'h2000_1234);
    axi_write(32'h4, 32'h0000_10FF);
    axi_write(32'h8, 32'h0000_4000);
    axi_write(32'hC, 32'h0000_5008);
    for (int i = 0; i < 4; i++) axi_read(4 * i);
    report_test("register access");

    @(posedge clk_i);
    req_i <= 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, 5'd0, '0);
    wait_new_instrs(8);
    // trap vector now follows the boot base
    axi_read(32'h4);
    report_test("boot and data");

    wait_new_instrs(20);
    report_test("sequential fetch and stall");

    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_1000);
    wait_new_instrs(6);
    redirect(PC_ERET, EXC_PC_EXC, 5'd0, '0);
    wait_new_instrs(6);
    redirect(PC_DRET, EXC_PC_EXC, 5'd0, '0);
    wait_new_instrs(6);
    report_test("jump and returns");

    redirect(PC_EXC, EXC_PC_EXC, 5'd0, '0);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_IRQ, 5'd5, '0);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_DBD, 5'd0, '0);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_DBG_EXC, 5'd0, '0);
    wait_new_instrs(4);
    report_test("exception targets");

    // error window ends at 0x30FF
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_30F0);
    wait_new_instrs(8);
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h0000_2FF8);
    wait_new_instrs(4);
    report_test("fetch error");

    repeat (5) @(posedge clk_i);
    $display("%0d tests run, %0d failures", test_cnt, total_fails());
    if (total_fails() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * 100);
    $display("watchdog expired, the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+design
design/if_pkg.sv
design/if_csr_regs.sv
design/if_pc_select.sv
design/if_fetch_buffer.sv
design/if_id_pipe.sv
design/if_stage_top.sv
sim/tb_clock_gen.sv
sim/if_stage_properties.sv
sim/tb_if_stage.sv

//--- Bender.yml
package:
  name: if_stage

sources:
  - include_dirs:
      - design
    files:
      - design/if_pkg.sv
      - design/if_csr_regs.sv
      - design/if_pc_select.sv
      - design/if_fetch_buffer.sv
      - design/if_id_pipe.sv
      - design/if_stage_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_clock_gen.sv
      - sim/if_stage_properties.sv
      - sim/tb_if_stage.sv
